// ==== design/div_pkg.sv ====
// Divide unit types

package div_pkg;

  // Bit 1 selects remainder, bit 0 selects unsigned
  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,
    OP_DIVU = 2'b01,
    OP_REM  = 2'b10,
    OP_REMU = 2'b11
  } div_op_t;

  // One operation as issued by decode
  typedef struct packed {
    div_op_t     op;
    logic [31:0] dividend;
    logic [31:0] divisor;
  } div_req_t;

  // Unsigned magnitudes out of the divider core
  typedef struct packed {
    logic [31:0] quot;
    logic [31:0] rem;
  } div_rsp_t;

endpackage

// ==== design/wb_pkg.sv ====
// Wishbone slave definitions

package wb_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat_r;
  } wb_rsp_t;

  // Word offsets, taken from adr[3:2]
  localparam logic [1:0] REG_OP1    = 2'd0;
  localparam logic [1:0] REG_OP2    = 2'd1;
  localparam logic [1:0] REG_CTRL   = 2'd2;
  localparam logic [1:0] REG_RESULT = 2'd3;

  // Status word bits
  localparam int STAT_BUSY = 0;
  localparam int STAT_DONE = 1;

endpackage

// ==== design/div_decode.sv ====
// Divider bus registers and decode
`timescale 1ns/100ps

module div_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  wb_pkg::wb_req_t   wb_req,
  output wb_pkg::wb_rsp_t   wb_rsp,
  input  logic              busy,
  input  logic              done,
  input  logic [31:0]       result_word,
  output logic              start,
  output div_pkg::div_req_t req
);
  import div_pkg::*;
  import wb_pkg::*;

  logic        ack;
  logic [31:0] dat_r;
  logic        access;
  logic [1:0]  word;
  logic        ctrl_wr;
  logic [31:0] op1;
  logic [31:0] op2;
  logic [31:0] status;
  logic [31:0] rd_data;

  // First cycle of a bus access only
  assign access = wb_req.cyc && wb_req.stb && !ack;
  assign word   = wb_req.adr[3:2];

  // Start refused while the divider is busy
  assign ctrl_wr = access && wb_req.we && (word == REG_CTRL) && !busy;

  always_comb begin
    status            = '0;
    status[STAT_BUSY] = busy;
    status[STAT_DONE] = done;
  end

  always_comb begin
    case (word)
      REG_OP1:  rd_data = op1;
      REG_OP2:  rd_data = op2;
      REG_CTRL: rd_data = status;
      default:  rd_data = result_word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack   <= 1'b0;
      start <= 1'b0;
    end else begin
      ack   <= access;
      start <= ctrl_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      dat_r <= rd_data;
    end
    if (access && wb_req.we) begin
      if (word == REG_OP1) begin
        op1 <= wb_req.dat_w;
      end
      if (word == REG_OP2) begin
        op2 <= wb_req.dat_w;
      end
    end
  end

  // Operands frozen here until the next accepted start
  always_ff @(posedge clk) begin
    if (ctrl_wr) begin
      req.op       <= div_op_t'(wb_req.dat_w[1:0]);
      req.dividend <= op1;
      req.divisor  <= op2;
    end
  end

  assign wb_rsp.ack   = ack;
  assign wb_rsp.dat_r = dat_r;

endmodule

// ==== design/div_execute.sv ====
// Iterative restoring divider
`timescale 1ns/100ps

module div_execute (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  div_pkg::div_req_t req,
  output logic              busy,
  output logic              fin,
  output div_pkg::div_rsp_t rsp
);
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FINAL
  } state_t;

  state_t      state;
  logic [4:0]  iter;
  logic [63:0] acc;
  logic        dvd_neg;
  logic        dsor_neg;
  logic [31:0] dvd_mag;
  logic [31:0] dsor_mag;
  logic [33:0] diff;
  logic [31:0] rem_next;

  // Operand signs only count for signed ops
  assign dvd_neg  = !req.op[0] && req.dividend[31];
  assign dsor_neg = !req.op[0] && req.divisor[31];

  assign dvd_mag  = dvd_neg ? (~req.dividend + 32'd1) : req.dividend;
  assign dsor_mag = dsor_neg ? (~req.divisor + 32'd1) : req.divisor;

  // Trial subtract of divisor from partial remainder
  assign diff = {1'b0, acc[63:31]} - {2'b00, dsor_mag};

  // Negative difference means restore
  assign rem_next = diff[33] ? acc[62:31] : diff[31:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      iter  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_RUN;
            iter  <= 5'd31;
          end
        end
        ST_RUN: begin
          iter <= iter - 5'd1;
          if (iter == 5'd0) begin
            state <= ST_FINAL;
          end
        end
        ST_FINAL: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Remainder in the upper half, quotient bits shift in below
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      acc <= {32'd0, dvd_mag};
    end else if (state == ST_RUN) begin
      acc <= {rem_next, acc[30:0], ~diff[33]};
    end
  end

  assign busy = (state != ST_IDLE);
  assign fin  = (state == ST_FINAL);

  assign rsp.quot = acc[31:0];
  assign rsp.rem  = acc[63:32];

endmodule

// ==== design/div_result.sv ====
// Divider result stage
`timescale 1ns/100ps

module div_result (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              fin,
  input  div_pkg::div_req_t req,
  input  div_pkg::div_rsp_t rsp,
  output logic              done,
  output logic [31:0]       result_word
);
  logic        is_rem;
  logic        dvd_neg;
  logic        dsor_neg;
  logic        negate;
  logic        div_zero;
  logic        overflow;
  logic [31:0] mag;
  logic [31:0] signed_val;
  logic [31:0] value;

  assign is_rem   = req.op[1];
  assign dvd_neg  = !req.op[0] && req.dividend[31];
  assign dsor_neg = !req.op[0] && req.divisor[31];

  assign div_zero = (req.divisor == 32'd0);
  // Signed minimum over minus one
  assign overflow = !req.op[0] && (req.dividend == 32'h8000_0000) &&
                    (req.divisor == 32'hffff_ffff);

  assign mag = is_rem ? rsp.rem : rsp.quot;

  // Remainder keeps the dividend sign
  assign negate     = dvd_neg ^ (!is_rem && dsor_neg);
  assign signed_val = negate ? (~mag + 32'd1) : mag;

  always_comb begin
    if (div_zero) begin
      value = is_rem ? req.dividend : 32'hffff_ffff;
    end else if (overflow) begin
      value = is_rem ? 32'd0 : req.dividend;
    end else begin
      value = signed_val;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done        <= 1'b0;
      result_word <= '0;
    end else if (fin) begin
      done        <= 1'b1;
      result_word <= value;
    end else if (start) begin
      done <= 1'b0;
    end
  end

endmodule

// ==== design/div_wb_top.sv ====
// Wishbone divide unit
`timescale 1ns/100ps

module div_wb_top (
  input  logic            clk,
  input  logic            rst_n,
  input  wb_pkg::wb_req_t wb_req,
  output wb_pkg::wb_rsp_t wb_rsp
);
  import div_pkg::*;

  logic        start;
  logic        busy;
  logic        fin;
  logic        done;
  logic [31:0] result_word;
  div_req_t    req;
  div_rsp_t    rsp;

  div_decode decode_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .busy        (busy),
    .done        (done),
    .result_word (result_word),
    .start       (start),
    .req         (req)
  );

  div_execute execute_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .req   (req),
    .busy  (busy),
    .fin   (fin),
    .rsp   (rsp)
  );

  div_result result_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .fin         (fin),
    .req         (req),
    .rsp         (rsp),
    .done        (done),
    .result_word (result_word)
  );

endmodule

// ==== sim/div_checker.sv ====
// Divide unit bus checker
`timescale 1ns/100ps

module div_checker (
  input logic            clk,
  input wb_pkg::wb_req_t wb_req,
  input wb_pkg::wb_rsp_t wb_rsp
);
  import wb_pkg::*;

  // Ack edges after an accepted CTRL write while the unit is busy
  localparam int BUSY_CYCLES = 34;

  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;
  int          start_cycle = 0;
  logic        started = 1'b0;
  logic [1:0]  run_op = 2'b00;
  logic [31:0] run_a = '0;
  logic [31:0] run_b = '0;
  logic [31:0] prev_result = '0;
  logic [31:0] op1 = '0;
  logic [31:0] op2 = '0;
  logic [1:0]  written = 2'b00;
  logic        ack_due = 1'b0;
  logic        busy_now;
  logic [1:0]  word;
  logic [31:0] exp_status;
  logic [31:0] exp_result;

  // RISC-V rules, signed ops truncate toward zero
  function automatic logic [31:0] expected_result(input logic [1:0] op, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [31:0]        val;
    sa = a;
    sb = b;
    if (b == 32'd0) begin
      val = op[1] ? a : 32'hffff_ffff;
    end else if (!op[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      val = op[1] ? 32'd0 : a;
    end else begin
      case (op)
        2'b00:   val = sa / sb;
        2'b01:   val = a / b;
        2'b10:   val = sa % sb;
        default: val = a % b;
      endcase
    end
    return val;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  assign word     = wb_req.adr[3:2];
  assign busy_now = started && (cycle - start_cycle <= BUSY_CYCLES);

  always_comb begin
    exp_status            = '0;
    exp_status[STAT_BUSY] = busy_now;
    exp_status[STAT_DONE] = started && !busy_now;
  end

  assign exp_result = busy_now ? prev_result :
                      (started ? expected_result(run_op, run_a, run_b) : 32'd0);

  always @(posedge clk) begin
    cycle <= cycle + 1;
    // Ack follows the first cycle of each access and lasts one cycle
    if (ack_due || wb_rsp.ack === 1'b1) begin
      compare("ack", {31'd0, wb_rsp.ack}, {31'd0, ack_due});
    end
    ack_due <= wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
      if (wb_req.we) begin
        if (word == REG_OP1) begin
          op1        <= wb_req.dat_w;
          written[0] <= 1'b1;
        end
        if (word == REG_OP2) begin
          op2        <= wb_req.dat_w;
          written[1] <= 1'b1;
        end
        // A start while busy is dropped by the unit
        if (word == REG_CTRL && !busy_now) begin
          prev_result <= exp_result;
          started     <= 1'b1;
          start_cycle <= cycle;
          run_op      <= wb_req.dat_w[1:0];
          run_a       <= op1;
          run_b       <= op2;
        end
      end else begin
        case (word)
          REG_OP1: begin
            if (written[0]) compare("OP1 readback", wb_rsp.dat_r, op1);
          end
          REG_OP2: begin
            if (written[1]) compare("OP2 readback", wb_rsp.dat_r, op2);
          end
          REG_CTRL: compare("status", wb_rsp.dat_r, exp_status);
          default: begin
            compare($sformatf("RESULT op %0d a %h b %h", run_op, run_a, run_b),
                    wb_rsp.dat_r, exp_result);
          end
        endcase
      end
    end
  end

endmodule

// ==== sim/div_tb.sv ====
// Divide unit testbench
`timescale 1ns/100ps

module div_tb;
  import wb_pkg::*;
  import div_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RAND_PAIRS = 200;
  localparam int NUM_OPS    = 4 * RAND_PAIRS + 40;

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [31:0] lfsr;

  div_wb_top dut_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  div_checker checker_i (
    .clk    (clk),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic bus_cycle(input logic we, input logic [1:0] word, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    @(posedge clk);
    wb_req.cyc   <= 1'b1;
    wb_req.stb   <= 1'b1;
    wb_req.we    <= we;
    wb_req.adr   <= {word, 2'b00};
    wb_req.dat_w <= wdata;
    do begin
      @(posedge clk);
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat_r;
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
  endtask

  task automatic wait_done();
    logic [31:0] status;
    status = '0;
    while (!status[STAT_DONE]) begin
      bus_cycle(1'b0, REG_CTRL, '0, status);
    end
  endtask

  task automatic run_op(input logic [1:0] op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] rd;
    bus_cycle(1'b1, REG_OP1, a, rd);
    bus_cycle(1'b1, REG_OP2, b, rd);
    bus_cycle(1'b1, REG_CTRL, {30'd0, op}, rd);
    wait_done();
    bus_cycle(1'b0, REG_RESULT, '0, rd);
  endtask

  task automatic run_all_ops(input logic [31:0] a, input logic [31:0] b);
    int k;
    for (k = 0; k < 4; k++) begin
      run_op(2'(k), a, b);
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rd;
    int          i;
    rst_n  = 1'b0;
    wb_req = '0;
    lfsr   = 32'h6f2c_71e6;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state, then operand readback
    bus_cycle(1'b0, REG_CTRL, '0, rd);
    bus_cycle(1'b0, REG_RESULT, '0, rd);
    bus_cycle(1'b1, REG_OP1, 32'h1234_5678, rd);
    bus_cycle(1'b1, REG_OP2, 32'h9abc_def0, rd);
    bus_cycle(1'b0, REG_OP1, '0, rd);
    bus_cycle(1'b0, REG_OP2, '0, rd);

    // Signed corners
    run_all_ops(32'hffff_ff9c, 32'd7);
    run_all_ops(32'd100, 32'hffff_fff9);
    run_all_ops(32'hffff_ff9c, 32'hffff_fff9);
    run_all_ops(32'd12345, 32'hffff_ffff);
    run_all_ops(32'hffff_cfc7, 32'd1);
    run_all_ops(32'hffff_cfc7, 32'hffff_ffff);

    // Divide by zero and overflow
    run_all_ops(32'hdead_beef, 32'd0);
    run_all_ops(32'd0, 32'd0);
    run_all_ops(32'h8000_0000, 32'hffff_ffff);

    // Second start lands while busy
    bus_cycle(1'b1, REG_OP1, 32'hffff_f000, rd);
    bus_cycle(1'b1, REG_OP2, 32'd9, rd);
    bus_cycle(1'b1, REG_CTRL, {30'd0, OP_DIV}, rd);
    bus_cycle(1'b1, REG_OP1, 32'h0000_0400, rd);
    bus_cycle(1'b1, REG_OP2, 32'd3, rd);
    bus_cycle(1'b1, REG_CTRL, {30'd0, OP_REMU}, rd);
    bus_cycle(1'b0, REG_RESULT, '0, rd);
    wait_done();
    bus_cycle(1'b0, REG_RESULT, '0, rd);
    bus_cycle(1'b0, REG_OP1, '0, rd);

    for (i = 0; i < RAND_PAIRS; i++) begin
      a = rand_bits(32);
      b = rand_bits(32) >> rand_bits(5);
      run_all_ops(a, b);
    end

    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checker_i.checks, checker_i.errors);
    if (checker_i.errors == 0 && checker_i.checks > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Roughly 50 cycles per operation, so 60 leaves room
  initial begin
    #(NUM_OPS * 60 * CLK_PERIOD + 2000);
    $display("Timeout: the run did not finish in time, errors so far: %0d", checker_i.errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== all.f ====
design/div_pkg.sv
design/wb_pkg.sv
design/div_decode.sv
design/div_execute.sv
design/div_result.sv
design/div_wb_top.sv
sim/div_checker.sv
sim/div_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := div_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(wildcard design/*.sv) $(wildcard sim/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
